/* alu_unit.sv */
`timescale 1ns/1ns

module alu_unit (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               req_valid,
    input  exec_pkg::alu_req_t req,
    output logic               req_ready,
    output logic               res_valid,
    output exec_pkg::cdb_t     res,
    input  logic               res_ready
);
    import exec_pkg::*;

    alu_state_t           state;
    logic [ALU_CNT_W-1:0] cnt;      // cycles left in busy
    cdb_t                 res_q;
    logic                 req_fire;

    function automatic logic [XLEN-1:0] alu_eval(
        input alu_func_t       func,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [4:0]      shamt;
        logic [XLEN-1:0] y;
        shamt = b[4:0];   // low five bits only
        case (func)
            fn_add:  y = a + b;
            fn_sub:  y = a - b;
            fn_and:  y = a & b;
            fn_or:   y = a | b;
            fn_xor:  y = a ^ b;
            fn_slt:  y = XLEN'($signed(a) < $signed(b));
            fn_sltu: y = XLEN'(a < b);
            fn_sll:  y = a << shamt;
            fn_srl:  y = a >> shamt;
            fn_sra:  y = $signed(a) >>> shamt;
            default: y = '0;
        endcase
        return y;
    endfunction

    assign req_ready = (state == st_idle);
    assign req_fire  = req_valid & req_ready;
    assign res_valid = (state == st_done);
    assign res       = res_q;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_fire) begin
                        state <= st_busy;
                        cnt   <= ALU_CNT_W'(ALU_LATENCY - 1);
                    end
                end
                st_busy: begin
                    if (cnt == '0) begin
                        state <= st_done;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                st_done: begin
                    // hold the result until the arbiter takes it
                    if (res_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // result computed up front, the counter only models latency
    always_ff @(posedge clk_in) begin
        if (req_fire) begin
            res_q.rob_ix <= req.rob_ix;
            res_q.data   <= alu_eval(req.func, req.a, req.b);
        end
    end

endmodule

/* cdb_arbiter.sv */
`timescale 1ns/1ns

module cdb_arbiter (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic [1:0]           res_valid,
    input  exec_pkg::cdb_t [1:0] res,
    output logic [1:0]           res_ready,
    output logic                 cdb_valid,
    output exec_pkg::cdb_t       cdb,
    input  logic                 cdb_ready
);

    logic last_win;     // unit granted on the last transfer
    logic hold;         // a stalled grant is pending
    logic hold_ix;
    logic grant;

    // a stalled grant is kept so the bus stays stable
    always_comb begin
        if (hold) begin
            grant = hold_ix;
        end else if (&res_valid) begin
            grant = ~last_win;      // loser of last round
        end else begin
            grant = res_valid[1];
        end
    end

    assign cdb_valid    = |res_valid;
    assign cdb          = res[grant];
    assign res_ready[0] = cdb_ready & ~grant;
    assign res_ready[1] = cdb_ready & grant;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            last_win <= 1'b0;
            hold     <= 1'b0;
            hold_ix  <= 1'b0;
        end else if (cdb_valid) begin
            if (cdb_ready) begin
                last_win <= grant;
                hold     <= 1'b0;
            end else begin
                hold     <= 1'b1;
                hold_ix  <= grant;
            end
        end
    end

endmodule

/* exec_cluster.sv */
`timescale 1ns/1ns

module exec_cluster (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             issue_valid,
    input  exec_pkg::issue_t issue,
    output logic             issue_ready,
    output logic             cdb_valid,
    output exec_pkg::cdb_t   cdb,
    input  logic             cdb_ready
);
    import exec_pkg::*;

    // station to units
    logic [1:0]     req_valid;
    logic [1:0]     req_ready;
    alu_req_t [1:0] req;

    // units to arbiter
    logic [1:0]     res_valid;
    logic [1:0]     res_ready;
    cdb_t [1:0]     res;

    reservation_station u_rs (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .cdb_valid   (cdb_valid),   // wakeup watches the result port
        .cdb_ready   (cdb_ready),
        .cdb         (cdb)
    );

    alu_unit alu_0 (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid[0]),
        .req       (req[0]),
        .req_ready (req_ready[0]),
        .res_valid (res_valid[0]),
        .res       (res[0]),
        .res_ready (res_ready[0])
    );

    alu_unit alu_1 (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid[1]),
        .req       (req[1]),
        .req_ready (req_ready[1]),
        .res_valid (res_valid[1]),
        .res       (res[1]),
        .res_ready (res_ready[1])
    );

    cdb_arbiter u_arb (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready),
        .cdb_valid (cdb_valid),
        .cdb       (cdb),
        .cdb_ready (cdb_ready)
    );

endmodule

/* exec_pkg.sv */
package exec_pkg;

    // datapath and tag widths
    localparam int XLEN        = 32;
    localparam int ROB_IX_W    = 3;    // eight tags in flight

    // reservation station size
    localparam int RS_DEPTH    = 4;
    localparam int RS_IX_W     = $clog2(RS_DEPTH);

    // alu timing
    localparam int ALU_LATENCY = 4;
    localparam int ALU_CNT_W   = $clog2(ALU_LATENCY);

    typedef enum logic [3:0] {
        fn_add,
        fn_sub,
        fn_and,
        fn_or,
        fn_xor,
        fn_slt,     // signed compare
        fn_sltu,    // unsigned compare
        fn_sll,
        fn_srl,     // logical right
        fn_sra      // arithmetic right
    } alu_func_t;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } alu_state_t;

    // value when ready, else producer tag in the low bits
    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] value;
    } operand_t;

    typedef struct packed {
        alu_func_t           func;
        logic [ROB_IX_W-1:0] rob_ix;
        operand_t            src1;
        operand_t            src2;
    } issue_t;

    typedef struct packed {
        alu_func_t           func;
        logic [ROB_IX_W-1:0] rob_ix;
        logic [XLEN-1:0]     a;
        logic [XLEN-1:0]     b;
    } alu_req_t;

    // unit result, bus beat and result port share this
    typedef struct packed {
        logic [ROB_IX_W-1:0] rob_ix;
        logic [XLEN-1:0]     data;
    } cdb_t;

endpackage

/* reservation_station.sv */
`timescale 1ns/1ns

module reservation_station (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     issue_valid,
    input  exec_pkg::issue_t         issue,
    output logic                     issue_ready,
    output logic [1:0]               req_valid,
    output exec_pkg::alu_req_t [1:0] req,
    input  logic [1:0]               req_ready,
    input  logic                     cdb_valid,
    input  logic                     cdb_ready,
    input  exec_pkg::cdb_t           cdb
);
    import exec_pkg::*;

    issue_t              ent [RS_DEPTH];
    logic [RS_DEPTH-1:0] ent_valid;
    logic [RS_IX_W-1:0]  ent_age [RS_DEPTH];    // number of younger valid entries
    logic [RS_IX_W-1:0]  age_next [RS_DEPTH];

    logic                issue_fire;
    logic                cdb_fire;
    logic [RS_IX_W-1:0]  free_ix;
    logic [RS_DEPTH-1:0] ent_ready;
    logic [RS_IX_W-1:0]  pick_ix [2];           // oldest, next oldest
    logic [1:0]          pick_found;
    logic [RS_IX_W-1:0]  unit_ix [2];
    logic [RS_DEPTH-1:0] dispatched;

    // grab bus data if this operand waits on the broadcast tag
    function automatic operand_t wake(input operand_t op, input logic hit_en, input cdb_t bus);
        operand_t r;
        r = op;
        if (hit_en && !op.ready && op.value[ROB_IX_W-1:0] == bus.rob_ix) begin
            r.ready = 1'b1;
            r.value = bus.data;
        end
        return r;
    endfunction

    assign issue_ready = ~&ent_valid;
    assign issue_fire  = issue_valid & issue_ready;
    assign cdb_fire    = cdb_valid & cdb_ready;

    always_comb begin
        free_ix = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_ix = RS_IX_W'(i);  // lowest free index wins
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ent_ready[i] = ent_valid[i] & ent[i].src1.ready & ent[i].src2.ready;
        end
    end

    // two passes of oldest-first search, second one skips the first pick
    always_comb begin
        logic [RS_IX_W-1:0] best_age;
        pick_found = '0;
        pick_ix[0] = '0;
        pick_ix[1] = '0;
        for (int p = 0; p < 2; p++) begin
            best_age = '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (ent_ready[i] && !(p == 1 && pick_found[0] && pick_ix[0] == RS_IX_W'(i))
                        && (!pick_found[p] || ent_age[i] > best_age)) begin
                    pick_found[p] = 1'b1;
                    pick_ix[p]    = RS_IX_W'(i);
                    best_age      = ent_age[i];
                end
            end
        end
    end

    // oldest to the first ready unit
    assign unit_ix[0]   = pick_ix[0];
    assign unit_ix[1]   = req_ready[0] ? pick_ix[1] : pick_ix[0];
    assign req_valid[0] = req_ready[0] & pick_found[0];
    assign req_valid[1] = req_ready[1] & (req_ready[0] ? pick_found[1] : pick_found[0]);

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            req[k].func   = ent[unit_ix[k]].func;
            req[k].rob_ix = ent[unit_ix[k]].rob_ix;
            req[k].a      = ent[unit_ix[k]].src1.value;
            req[k].b      = ent[unit_ix[k]].src2.value;
        end
    end

    always_comb begin
        dispatched = '0;
        for (int k = 0; k < 2; k++) begin
            if (req_valid[k]) begin
                dispatched[unit_ix[k]] = 1'b1;  // valid only with ready, so taken
            end
        end
    end

    // keep ages dense: +1 for a new entry, -1 per younger entry leaving
    always_comb begin
        logic [RS_IX_W-1:0] n_freed;
        for (int i = 0; i < RS_DEPTH; i++) begin
            n_freed = '0;
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (dispatched[j] && ent_age[j] < ent_age[i]) begin
                    n_freed = n_freed + 1'b1;
                end
            end
            age_next[i] = ent_age[i] + RS_IX_W'(issue_fire) - n_freed;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ent_valid <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                ent_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (dispatched[i]) begin
                    ent_valid[i] <= 1'b0;
                end else if (ent_valid[i]) begin
                    ent_age[i] <= age_next[i];
                end
            end
            if (issue_fire) begin
                ent_valid[free_ix] <= 1'b1;
                ent_age[free_ix]   <= '0;   // youngest
            end
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ent[i].src1 <= wake(ent[i].src1, cdb_fire, cdb);
            ent[i].src2 <= wake(ent[i].src2, cdb_fire, cdb);
        end
        if (issue_fire) begin
            ent[free_ix].func   <= issue.func;
            ent[free_ix].rob_ix <= issue.rob_ix;
            ent[free_ix].src1   <= wake(issue.src1, cdb_fire, cdb);   // same-cycle bypass
            ent[free_ix].src2   <= wake(issue.src2, cdb_fire, cdb);
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the exec_cluster testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_cluster \
    -f src.f --Mdir obj_dir -o sim_exec_cluster
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_exec_cluster)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* src.f */
exec_pkg.sv
alu_unit.sv
reservation_station.sv
cdb_arbiter.sv
exec_cluster.sv
tb_exec_cluster.sv

/* tb_exec_cluster.sv */
`timescale 1ns/1ns

module tb_exec_cluster;
    import exec_pkg::*;

    localparam int N_TAGS      = 2 ** ROB_IX_W;
    localparam int N_DIRECTED  = 12;
    localparam int N_RANDOM    = 48;
    localparam int N_CHAINS    = 4;
    localparam int CHAIN_LEN   = 4;
    localparam int TOTAL_OPS   = N_DIRECTED + N_RANDOM + N_CHAINS * CHAIN_LEN + 12;
    localparam int CYCLE_LIMIT = 4 * TOTAL_OPS * (ALU_LATENCY + 2) + 500;

    logic   clk_in;
    logic   rst_in;
    logic   issue_valid;
    issue_t issue;
    logic   issue_ready;
    logic   cdb_valid;
    cdb_t   cdb;
    logic   cdb_ready;

    // model of tags in flight
    logic [N_TAGS-1:0]   in_flight;
    logic [XLEN-1:0]     exp_val [N_TAGS];
    int                  issue_cycle [N_TAGS];   // edge of the issue transfer
    int                  valid_cycle [N_TAGS];   // first cycle seen on the bus
    logic [ROB_IX_W-1:0] tag_ptr;
    logic [ROB_IX_W-1:0] last_tag;

    int          errors;
    int          issued;
    int          delivered;
    int          cycles;
    int          release_cycle;                  // scheduled end of a result port stall
    logic        random_stall;
    logic [31:0] lfsr;
    logic        prev_valid;
    logic        prev_ready;
    cdb_t        prev_cdb;

    exec_cluster UUT (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .cdb_ready   (cdb_ready)
    );

    always #50 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d results delivered",
                     cycles, delivered, issued);
            $display("errors: %0d, issued: %0d, delivered: %0d", errors, issued, delivered);
            $display("Simulation failed");
            $finish;
        end
    end

    // bus checks, sampled mid-cycle where everything has settled
    always @(negedge clk_in) begin
        if (!rst_in) begin
            if (prev_valid && !prev_ready) begin
                assert (cdb_valid && cdb == prev_cdb) else begin
                    $display("Error: cdb moved while stalled, cdb_valid %h cdb %h, held %h",
                             cdb_valid, cdb, prev_cdb);
                    errors++;
                end
            end
            if (cdb_valid && in_flight[cdb.rob_ix] && valid_cycle[cdb.rob_ix] < 0) begin
                valid_cycle[cdb.rob_ix] = cycles;
            end
            if (cdb_valid && cdb_ready) begin
                assert (in_flight[cdb.rob_ix]) else begin
                    $display("Result for rob_ix %0d arrived with no operation in flight",
                             cdb.rob_ix);
                    errors++;
                end
                assert (cdb.data == exp_val[cdb.rob_ix]) else begin
                    $display("Error: cdb.data for rob_ix %h is %h, expected %h",
                             cdb.rob_ix, cdb.data, exp_val[cdb.rob_ix]);
                    errors++;
                end
                in_flight[cdb.rob_ix] = 1'b0;
                delivered++;
            end
        end
        prev_valid = cdb_valid & ~rst_in;
        prev_ready = cdb_ready;
        prev_cdb   = cdb;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [XLEN-1:0] ref_result(input alu_func_t f,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] ext;
        int                sh;
        sh  = int'(b[4:0]);
        ext = {{XLEN{a[XLEN-1]}}, a};   // sign-extended copy for sra
        case (f)
            fn_add:  return a + b;
            fn_sub:  return a - b;
            fn_and:  return a & b;
            fn_or:   return a | b;
            fn_xor:  return a ^ b;
            fn_slt:  return (a[XLEN-1] != b[XLEN-1]) ? {31'b0, a[XLEN-1]} : {31'b0, a < b};
            fn_sltu: return {31'b0, a < b};
            fn_sll:  return a << sh;
            fn_srl:  return a >> sh;
            fn_sra:  return XLEN'(ext >> sh);
            default: return '0;
        endcase
    endfunction

    function automatic logic find_free_tag(output logic [ROB_IX_W-1:0] tag);
        logic                found;
        logic [ROB_IX_W-1:0] cand;
        found = 1'b0;
        tag   = tag_ptr;
        for (int i = 0; i < N_TAGS; i++) begin
            cand = ROB_IX_W'(int'(tag_ptr) + i);
            if (!found && !in_flight[cand]) begin
                found = 1'b1;
                tag   = cand;
            end
        end
        return found;
    endfunction

    task automatic next_cycle();
        @(posedge clk_in);
        #10;
        if (release_cycle >= 0 && cycles >= release_cycle) begin
            cdb_ready     = 1'b1;
            release_cycle = -1;
        end else if (random_stall) begin
            cdb_ready = (rand_bits(2) != 0);   // busy rob one cycle in four
        end
    endtask

    task automatic build_operand(input logic dep, input logic [ROB_IX_W-1:0] tag,
                                 input logic [XLEN-1:0] v, output operand_t op,
                                 output logic [XLEN-1:0] val);
        if (dep && in_flight[tag]) begin
            op.ready = 1'b0;
            op.value = XLEN'(tag);
            val      = exp_val[tag];     // producer's expected result
        end else begin
            op.ready = 1'b1;
            op.value = v;
            val      = v;
        end
    endtask

    task automatic send_op(input alu_func_t func, input logic dep1,
                           input logic [ROB_IX_W-1:0] t1, input logic [XLEN-1:0] a,
                           input logic dep2, input logic [ROB_IX_W-1:0] t2,
                           input logic [XLEN-1:0] b, input logic need_ready);
        issue_t              op;
        logic [XLEN-1:0]     va;
        logic [XLEN-1:0]     vb;
        logic [ROB_IX_W-1:0] tag;
        logic                xfer;
        // tagged operands only go out when the transfer is certain this cycle
        while (!find_free_tag(tag) || (need_ready && !issue_ready)) begin
            next_cycle();
        end
        build_operand(dep1, t1, a, op.src1, va);
        build_operand(dep2, t2, b, op.src2, vb);
        op.func          = func;
        op.rob_ix        = tag;
        exp_val[tag]     = ref_result(func, va, vb);
        in_flight[tag]   = 1'b1;
        valid_cycle[tag] = -1;
        tag_ptr          = ROB_IX_W'(tag + 1);
        last_tag         = tag;
        issued++;
        issue       = op;
        issue_valid = 1'b1;
        do begin
            xfer = issue_ready;
            next_cycle();
        end while (!xfer);
        issue_valid      = 1'b0;
        issue_cycle[tag] = cycles;
    endtask

    task automatic send_value(input alu_func_t func, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b);
        send_op(func, 1'b0, '0, a, 1'b0, '0, b, 1'b1);
    endtask

    // src1 chains on the previous op when dep_ok, src2 on a random tag now and then
    task automatic send_random(input logic dep_ok, input logic need_ready);
        alu_func_t           func;
        logic                dep2;
        logic [ROB_IX_W-1:0] t2;
        logic [XLEN-1:0]     a;
        logic [XLEN-1:0]     b;
        func = alu_func_t'(4'(rand_bits(4) % 10));
        dep2 = dep_ok && (rand_bits(2) == 0);
        t2   = ROB_IX_W'(rand_bits(ROB_IX_W));
        a    = rand_bits(XLEN);
        b    = rand_bits(XLEN);
        send_op(func, dep_ok, last_tag, a, dep2, t2, b, need_ready);
    endtask

    task automatic drain();
        while (in_flight != '0) begin
            next_cycle();
        end
    endtask

    initial begin
        logic [ROB_IX_W-1:0] tag_a;
        logic [XLEN-1:0]     val;
        clk_in        = 1'b0;
        rst_in        = 1'b1;
        issue_valid   = 1'b0;
        issue         = '0;
        cdb_ready     = 1'b1;
        lfsr          = 32'hd860;
        errors        = 0;
        issued        = 0;
        delivered     = 0;
        cycles        = 0;
        release_cycle = -1;
        random_stall  = 1'b0;
        in_flight     = '0;
        tag_ptr       = '0;
        last_tag      = '0;
        prev_valid    = 1'b0;
        prev_ready    = 1'b1;
        prev_cdb      = '0;
        for (int i = 0; i < N_TAGS; i++) begin
            exp_val[i]     = '0;
            issue_cycle[i] = 0;
            valid_cycle[i] = -1;
        end
        repeat (5) @(posedge clk_in);
        #10;
        rst_in = 1'b0;
        assert (issue_ready && !cdb_valid) else begin
            $display("Error: after reset issue_ready %h cdb_valid %h", issue_ready, cdb_valid);
            errors++;
        end

        // lone op on an idle cluster
        send_value(fn_add, 32'h0000_1234, 32'h0000_4321);
        tag_a = last_tag;
        drain();
        assert (valid_cycle[tag_a] - issue_cycle[tag_a] == 1 + ALU_LATENCY) else begin
            $display("Error: cdb_valid latency %h, expected %h",
                     valid_cycle[tag_a] - issue_cycle[tag_a], 1 + ALU_LATENCY);
            errors++;
        end

        // back to back, both units busy at once
        send_value(fn_sub, 32'h0000_0010, 32'h0000_0020);
        tag_a = last_tag;
        send_value(fn_xor, 32'hff00_ff00, 32'h0ff0_0ff0);
        drain();
        assert (valid_cycle[last_tag] - issue_cycle[tag_a] <= 2 + ALU_LATENCY) else begin
            $display("Error: second cdb_valid %h cycles after first issue, limit %h",
                     valid_cycle[last_tag] - issue_cycle[tag_a], 2 + ALU_LATENCY);
            errors++;
        end

        send_value(fn_slt,  32'hffff_fffb, 32'h0000_0003);
        send_value(fn_slt,  32'h0000_0003, 32'hffff_fffb);
        send_value(fn_sltu, 32'hffff_fffb, 32'h0000_0003);
        send_value(fn_sltu, 32'h0000_0003, 32'hffff_fffb);
        send_value(fn_sra,  32'h8000_0010, 32'h0000_0004);
        send_value(fn_sra,  32'hffff_fff0, 32'h0000_001f);
        send_value(fn_srl,  32'h8000_0010, 32'h0000_0004);
        send_value(fn_srl,  32'hf000_0000, 32'h0000_001f);
        send_value(fn_sll,  32'h0000_0001, 32'h0000_001f);
        send_value(fn_sll,  32'h0000_00ff, 32'h0000_0020);   // amount wraps to 0
        send_value(fn_srl,  32'h8000_0000, 32'h0000_003f);
        send_value(fn_sra,  32'h8000_0000, 32'h0000_0021);

        random_stall = 1'b1;
        repeat (N_RANDOM) send_random(1'b0, 1'b1);
        for (int c = 0; c < N_CHAINS; c++) begin
            send_random(1'b0, 1'b1);
            repeat (CHAIN_LEN - 1) send_random(1'b1, 1'b1);
        end
        drain();
        random_stall = 1'b0;
        cdb_ready    = 1'b1;

        // consumer issued on the producer's bus transfer
        val = rand_bits(XLEN);
        send_value(fn_add, val, rand_bits(XLEN));
        tag_a = last_tag;
        while (!(cdb_valid && cdb_ready && cdb.rob_ix == tag_a)) begin
            next_cycle();
        end
        assert (issue_ready) else begin
            $display("Could not issue in the same cycle as the producer result");
            errors++;
        end
        send_op(fn_sub, 1'b1, tag_a, '0, 1'b0, '0, val, 1'b1);
        drain();

        // rob busy, station fills up
        cdb_ready = 1'b0;
        repeat (6) send_random(1'b0, 1'b1);
        for (int i = 0; i < 8 && issue_ready; i++) begin
            next_cycle();
        end
        assert (!issue_ready) else begin
            $display("issue_ready stayed high with the result port stalled");
            errors++;
        end
        release_cycle = cycles + 4;
        send_random(1'b0, 1'b0);
        drain();

        assert (issued == delivered) else begin
            $display("%0d operations issued but %0d results delivered", issued, delivered);
            errors++;
        end
        $display("errors: %0d, issued: %0d, delivered: %0d", errors, issued, delivered);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
